// File: logic/rv_pkg.sv
package rv_pkg;

	localparam int XLEN        = 64;             // Register and data width
	localparam int ADDR_W      = 32;             // AXI4-Lite address width
	localparam int BUS_TIMEOUT = 64;             // Max wait cycles per transaction

	localparam logic [XLEN-1:0] RESET_PC = '0;   // First fetch address

	// Multi-cycle sequencer states
	typedef enum logic [2:0] {
		FETCH_ADDR,
		FETCH_DATA,
		EXECUTE,
		MEM_ADDR,
		MEM_DATA,
		HALT
	} seq_state_e;

	// RV64I major opcodes, instr[6:0]
	typedef enum logic [6:0] {
		OP_IMM = 7'b0010011,
		OP     = 7'b0110011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111,
		LOAD   = 7'b0000011,
		STORE  = 7'b0100011,
		BRANCH = 7'b1100011,
		JAL    = 7'b1101111,
		JALR   = 7'b1100111,
		SYSTEM = 7'b1110011
	} opcode_e;

	// ALU operations
	typedef enum logic [2:0] {
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		SLT,     // Signed compare
		PASS_B   // Forward operand b, used by lui
	} alu_op_e;

	// Register write-back source
	typedef enum logic [1:0] {
		ALU,
		MEM,
		PC_PLUS4
	} wb_sel_e;

endpackage

// File: logic/alu.sv
`timescale 1ns/1ps

module alu import rv_pkg::*; (
	input  alu_op_e         op,
	input  logic [XLEN-1:0] a,
	input  logic [XLEN-1:0] b,
	output logic [XLEN-1:0] result,
	output logic            zero
);

	logic lt;

	// Signed less-than for slt
	assign lt = $signed(a) < $signed(b);

	always_comb begin
		case (op)
			ADD: begin
				result = a + b;
			end
			SUB: begin
				result = a - b;
			end
			AND: begin
				result = a & b;
			end
			OR: begin
				result = a | b;
			end
			XOR: begin
				result = a ^ b;
			end
			SLT: begin
				result = {{(XLEN-1){1'b0}}, lt};
			end
			PASS_B: begin
				result = b;
			end
			default: begin
				result = '0;
			end
		endcase
	end

	assign zero = (result == '0); // Used for beq and bne

endmodule

// File: logic/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
	input  logic            clk,
	input  logic            rst,
	input  logic [4:0]      rs1,
	input  logic [4:0]      rs2,
	input  logic [4:0]      rd,
	input  logic            rd_write,
	input  logic [XLEN-1:0] rd_data,
	output logic [XLEN-1:0] rs1_data,
	output logic [XLEN-1:0] rs2_data
);

	logic [XLEN-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end else if (rd_write && rd != 5'd0) begin // x0 stays zero
			regs[rd] <= rd_data;
		end
	end

	// Combinational reads
	assign rs1_data = (rs1 == 5'd0) ? '0 : regs[rs1];
	assign rs2_data = (rs2 == 5'd0) ? '0 : regs[rs2];

endmodule

// File: logic/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder import rv_pkg::*; (
	input  logic [31:0]     instr,
	output logic [4:0]      rs1,
	output logic [4:0]      rs2,
	output logic [4:0]      rd,
	output logic [XLEN-1:0] imm,
	output alu_op_e         alu_op,
	output logic            src_a_pc,
	output logic            src_b_imm,
	output wb_sel_e         wb_sel,
	output logic            reg_write,
	output logic            mem_read,
	output logic            mem_write,
	output logic            branch,
	output logic            branch_ne,
	output logic            jump,
	output logic            jump_reg,
	output logic            halt_req,
	output logic            illegal
);

	opcode_e         opcode;
	logic [2:0]      funct3;
	logic [6:0]      funct7;
	logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;

	assign opcode = opcode_e'(instr[6:0]);
	assign rd     = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1    = instr[19:15];
	assign rs2    = instr[24:20];
	assign funct7 = instr[31:25];

	// Sign-extended immediates
	assign imm_i = {{52{instr[31]}}, instr[31:20]};
	assign imm_s = {{52{instr[31]}}, instr[31:25], instr[11:7]};
	assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
	assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
	assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

	always_comb begin
		imm = '0;
		alu_op = ADD;
		src_a_pc = 1'b0;
		src_b_imm = 1'b0;
		wb_sel = ALU;
		reg_write = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		branch = 1'b0;
		branch_ne = 1'b0;
		jump = 1'b0;
		jump_reg = 1'b0;
		halt_req = 1'b0;
		illegal = 1'b0;
		case (opcode)
			OP_IMM: begin // addi only
				imm = imm_i;
				src_b_imm = 1'b1;
				reg_write = (funct3 == 3'b000);
				illegal = (funct3 != 3'b000);
			end
			OP: begin
				reg_write = 1'b1;
				case ({funct7, funct3})
					{7'h00, 3'b000}: alu_op = ADD;
					{7'h20, 3'b000}: alu_op = SUB;
					{7'h00, 3'b111}: alu_op = AND;
					{7'h00, 3'b110}: alu_op = OR;
					{7'h00, 3'b100}: alu_op = XOR;
					{7'h00, 3'b010}: alu_op = SLT;
					default: begin
						reg_write = 1'b0;
						illegal = 1'b1;
					end
				endcase
			end
			LUI: begin
				imm = imm_u;
				alu_op = PASS_B;
				src_b_imm = 1'b1;
				reg_write = 1'b1;
			end
			AUIPC: begin
				imm = imm_u;
				src_a_pc = 1'b1;
				src_b_imm = 1'b1;
				reg_write = 1'b1;
			end
			LOAD: begin // ld only, address is rs1 + imm
				imm = imm_i;
				src_b_imm = 1'b1;
				wb_sel = MEM;
				mem_read = (funct3 == 3'b011);
				reg_write = (funct3 == 3'b011);
				illegal = (funct3 != 3'b011);
			end
			STORE: begin // sd only
				imm = imm_s;
				src_b_imm = 1'b1;
				mem_write = (funct3 == 3'b011);
				illegal = (funct3 != 3'b011);
			end
			BRANCH: begin
				imm = imm_b;
				alu_op = SUB; // Zero flag means equal
				branch = (funct3[2:1] == 2'b00);
				branch_ne = funct3[0];
				illegal = (funct3[2:1] != 2'b00);
			end
			JAL: begin
				imm = imm_j;
				wb_sel = PC_PLUS4;
				jump = 1'b1;
				reg_write = 1'b1;
			end
			JALR: begin
				imm = imm_i;
				src_b_imm = 1'b1;
				wb_sel = PC_PLUS4;
				jump_reg = (funct3 == 3'b000);
				reg_write = (funct3 == 3'b000);
				illegal = (funct3 != 3'b000);
			end
			SYSTEM: begin
				halt_req = (instr[31:7] == '0); // ecall
				illegal = (instr[31:7] != '0);
			end
			default: illegal = 1'b1;
		endcase
	end

endmodule

// File: logic/bus_timeout_timer.sv
`timescale 1ns/1ps

module bus_timeout_timer import rv_pkg::*; (
	input  logic clk,
	input  logic rst,
	input  logic busy,
	input  logic done,
	output logic timeout
);

	localparam int CNT_W = $clog2(BUS_TIMEOUT + 1);

	logic [CNT_W-1:0] count;

	always_ff @(posedge clk) begin
		if (rst || done || !busy)
			count <= '0;
		else if (!timeout)
			count <= count + 1'b1; // Saturates at the limit
	end

	assign timeout = (count == CNT_W'(BUS_TIMEOUT));

endmodule

// File: logic/exec_sequencer.sv
`timescale 1ns/1ps

module exec_sequencer import rv_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	output logic [ADDR_W-1:0] awaddr,
	output logic              awvalid,
	input  logic              awready,
	output logic [XLEN-1:0]   wdata,
	output logic [XLEN/8-1:0] wstrb,
	output logic              wvalid,
	input  logic              wready,
	input  logic [1:0]        bresp,
	input  logic              bvalid,
	output logic              bready,
	output logic [ADDR_W-1:0] araddr,
	output logic              arvalid,
	input  logic              arready,
	input  logic [XLEN-1:0]   rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready,
	input  logic              src_a_pc,
	input  logic              src_b_imm,
	input  wb_sel_e           wb_sel,
	input  logic              reg_write,
	input  logic              mem_read,
	input  logic              mem_write,
	input  logic              branch,
	input  logic              branch_ne,
	input  logic              jump,
	input  logic              jump_reg,
	input  logic              halt_req,
	input  logic              illegal,
	input  logic [XLEN-1:0]   imm,
	input  logic [XLEN-1:0]   rs1_data,
	input  logic [XLEN-1:0]   rs2_data,
	input  logic [XLEN-1:0]   alu_result,
	input  logic              alu_zero,
	input  logic              timeout,
	output logic [31:0]       instr,
	output logic [XLEN-1:0]   alu_a,
	output logic [XLEN-1:0]   alu_b,
	output logic              rd_write,
	output logic [XLEN-1:0]   rd_data,
	output logic              busy,
	output logic              done,
	output logic              halted,
	output logic              illegal_inst,
	output logic              bus_error
);

	seq_state_e      state;
	logic [XLEN-1:0] pc;
	logic [XLEN-1:0] load_data;
	logic [XLEN-1:0] pc_plus4, next_pc;
	logic            aw_done, w_done;   // Store channel already transferred
	logic            aw_fin, w_fin;
	logic            taken;
	opcode_e         opcode;

	assign opcode   = opcode_e'(instr[6:0]);
	assign pc_plus4 = pc + XLEN'(4);
	assign taken    = branch && (alu_zero ^ branch_ne);

	always_comb begin
		if (jump_reg)
			next_pc = {alu_result[XLEN-1:1], 1'b0}; // jalr clears bit 0
		else if (jump || taken)
			next_pc = pc + imm;
		else
			next_pc = pc_plus4;
	end

	assign alu_a = src_a_pc ? pc : rs1_data;
	assign alu_b = src_b_imm ? imm : rs2_data;

	always_comb begin
		case (wb_sel)
			MEM:      rd_data = load_data;
			PC_PLUS4: rd_data = pc_plus4;
			default:  rd_data = alu_result;
		endcase
	end

	// Loads write back from the data register while the next fetch starts
	assign rd_write = (state == EXECUTE && reg_write && !mem_read) ||
	                  (state == FETCH_ADDR && opcode == LOAD && reg_write);

	assign arvalid = (state == FETCH_ADDR) || (state == MEM_ADDR && mem_read);
	assign araddr  = (state == FETCH_ADDR) ? {pc[ADDR_W-1:3], 3'b000} : alu_result[ADDR_W-1:0];
	assign rready  = (state == FETCH_DATA) || (state == MEM_DATA);
	assign awvalid = (state == MEM_ADDR) && mem_write && !aw_done;
	assign wvalid  = (state == MEM_ADDR) && mem_write && !w_done;
	assign awaddr  = alu_result[ADDR_W-1:0];
	assign wdata   = rs2_data;
	assign wstrb   = '1;
	assign bready  = (state == MEM_DATA) && mem_write;

	assign aw_fin = aw_done || (awvalid && awready);
	assign w_fin  = w_done || (wvalid && wready);

	assign busy   = state inside {FETCH_ADDR, FETCH_DATA, MEM_ADDR, MEM_DATA};
	assign done   = (rvalid && rready) || (bvalid && bready);
	assign halted = (state == HALT);

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= FETCH_ADDR;
			pc           <= RESET_PC;
			instr        <= '0;
			aw_done      <= 1'b0;
			w_done       <= 1'b0;
			illegal_inst <= 1'b0;
			bus_error    <= 1'b0;
		end else if (busy && timeout) begin
			state     <= HALT;
			bus_error <= 1'b1;
		end else begin
			case (state)
				FETCH_ADDR: if (arready) state <= FETCH_DATA;
				FETCH_DATA: if (rvalid) begin
					if (rresp != 2'b00) begin
						state     <= HALT;
						bus_error <= 1'b1;
					end else begin
						instr <= pc[2] ? rdata[63:32] : rdata[31:0]; // Pick half word
						state <= EXECUTE;
					end
				end
				EXECUTE: begin
					if (halt_req || illegal) begin
						state        <= HALT;
						illegal_inst <= illegal;
					end else begin
						pc    <= next_pc;
						state <= (mem_read || mem_write) ? MEM_ADDR : FETCH_ADDR;
					end
				end
				MEM_ADDR: begin
					if (mem_write) begin
						if (aw_fin && w_fin) begin
							aw_done <= 1'b0;
							w_done  <= 1'b0;
							state   <= MEM_DATA;
						end else begin
							aw_done <= aw_fin;
							w_done  <= w_fin;
						end
					end else if (arready) begin
						state <= MEM_DATA;
					end
				end
				MEM_DATA: begin
					if (mem_write ? bvalid : rvalid) begin
						if ((mem_write ? bresp : rresp) != 2'b00) begin
							state     <= HALT;
							bus_error <= 1'b1;
						end else begin
							state <= FETCH_ADDR;
						end
					end
				end
				default: state <= HALT; // Stay stopped until reset
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == MEM_DATA && rvalid && !mem_write)
			load_data <= rdata;
	end

endmodule

// File: logic/core_top.sv
`timescale 1ns/1ps

module core_top import rv_pkg::*; (
	input  logic              clk,
	input  logic              rst,
	// AXI4-Lite write address
	output logic [ADDR_W-1:0] awaddr,
	output logic              awvalid,
	input  logic              awready,
	// AXI4-Lite write data
	output logic [XLEN-1:0]   wdata,
	output logic [XLEN/8-1:0] wstrb,
	output logic              wvalid,
	input  logic              wready,
	// AXI4-Lite write response
	input  logic [1:0]        bresp,
	input  logic              bvalid,
	output logic              bready,
	// AXI4-Lite read address
	output logic [ADDR_W-1:0] araddr,
	output logic              arvalid,
	input  logic              arready,
	// AXI4-Lite read data
	input  logic [XLEN-1:0]   rdata,
	input  logic [1:0]        rresp,
	input  logic              rvalid,
	output logic              rready,
	// Status
	output logic              halted,
	output logic              illegal_inst,
	output logic              bus_error
);

	logic [31:0]     instr;
	logic [4:0]      rs1, rs2, rd;
	logic [XLEN-1:0] imm;
	alu_op_e         alu_op;
	wb_sel_e         wb_sel;
	logic            src_a_pc, src_b_imm;
	logic            reg_write, mem_read, mem_write;
	logic            branch, branch_ne, jump, jump_reg;
	logic            halt_req, illegal;

	logic [XLEN-1:0] rs1_data, rs2_data;
	logic [XLEN-1:0] alu_a, alu_b, alu_result;
	logic            alu_zero;
	logic            rd_write;
	logic [XLEN-1:0] rd_data;
	logic            busy, done, timeout;

	exec_sequencer u_exec_sequencer (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.src_a_pc(src_a_pc), .src_b_imm(src_b_imm), .wb_sel(wb_sel),
		.reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
		.branch(branch), .branch_ne(branch_ne), .jump(jump), .jump_reg(jump_reg),
		.halt_req(halt_req), .illegal(illegal), .imm(imm),
		.rs1_data(rs1_data), .rs2_data(rs2_data),
		.alu_result(alu_result), .alu_zero(alu_zero), .timeout(timeout),
		.instr(instr), .alu_a(alu_a), .alu_b(alu_b),
		.rd_write(rd_write), .rd_data(rd_data), .busy(busy), .done(done),
		.halted(halted), .illegal_inst(illegal_inst), .bus_error(bus_error)
	);

	inst_decoder u_inst_decoder (
		.instr(instr), .rs1(rs1), .rs2(rs2), .rd(rd), .imm(imm),
		.alu_op(alu_op), .src_a_pc(src_a_pc), .src_b_imm(src_b_imm),
		.wb_sel(wb_sel), .reg_write(reg_write),
		.mem_read(mem_read), .mem_write(mem_write),
		.branch(branch), .branch_ne(branch_ne), .jump(jump), .jump_reg(jump_reg),
		.halt_req(halt_req), .illegal(illegal)
	);

	alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result), .zero(alu_zero));

	reg_file u_reg_file (
		.clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .rd(rd),
		.rd_write(rd_write), .rd_data(rd_data),
		.rs1_data(rs1_data), .rs2_data(rs2_data)
	);

	bus_timeout_timer u_bus_timeout_timer (
		.clk(clk), .rst(rst), .busy(busy), .done(done), .timeout(timeout)
	);

endmodule

// File: test/axi_lite_mem.sv
`timescale 1ns/1ps

module axi_lite_mem (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall_en,   // Random wait cycles on every channel
	input  logic [31:0] awaddr,
	input  logic        awvalid,
	output logic        awready,
	input  logic [63:0] wdata,
	input  logic [7:0]  wstrb,
	input  logic        wvalid,
	output logic        wready,
	output logic [1:0]  bresp,
	output logic        bvalid,
	input  logic        bready,
	input  logic [31:0] araddr,
	input  logic        arvalid,
	output logic        arready,
	output logic [63:0] rdata,
	output logic [1:0]  rresp,
	output logic        rvalid,
	input  logic        rready
);

	localparam int WORDS = 8192; // 64 KiB of 64-bit words

	logic [63:0] mem [WORDS];
	logic [2:0]  ar_cnt, r_cnt, aw_cnt, w_cnt, b_cnt;
	logic        rd_pend, aw_got, w_got;
	logic [31:0] rd_addr, wr_addr;
	logic [63:0] wr_data;
	logic [7:0]  wr_strb;

	assign bresp = 2'b00;
	assign rresp = 2'b00;

	function automatic logic [2:0] pick_stall();
		return stall_en ? 3'($urandom_range(7, 0)) : 3'd0;
	endfunction

	// Upper half of the address space is a hole that never answers
	function automatic logic mapped(input logic [31:0] a);
		return !a[31];
	endfunction

	function automatic logic [63:0] fill_value(input logic [31:0] a);
		return {~a, a};
	endfunction

	// Only the bytes enabled by the strobe take the new data
	function automatic logic [63:0] merge_bytes(input logic [63:0] old, input logic [63:0] data,
			input logic [7:0] strb);
		logic [63:0] r;
		r = old;
		for (int b = 0; b < 8; b++)
			if (strb[b])
				r[b*8 +: 8] = data[b*8 +: 8];
		return r;
	endfunction

	task automatic fill_all();
		for (int i = 0; i < WORDS; i++)
			mem[i] = fill_value(32'(i * 8));
	endtask

	task automatic load_word(input logic [31:0] a, input logic [63:0] d);
		mem[a[15:3]] = d;
	endtask

	function automatic logic [63:0] peek(input logic [31:0] a);
		return mem[a[15:3]];
	endfunction

	always @(posedge clk) begin
		if (rst) begin
			arready <= 1'b0;
			awready <= 1'b0;
			wready  <= 1'b0;
			rvalid  <= 1'b0;
			bvalid  <= 1'b0;
			rdata   <= '0;
			rd_pend <= 1'b0;
			aw_got  <= 1'b0;
			w_got   <= 1'b0;
			ar_cnt  <= '0;
			r_cnt   <= '0;
			aw_cnt  <= '0;
			w_cnt   <= '0;
			b_cnt   <= '0;
		end else begin
			arready <= 1'b0; // Ready is a one-cycle pulse
			awready <= 1'b0;
			wready  <= 1'b0;
			if (rvalid && rready)
				rvalid <= 1'b0;
			if (bvalid && bready)
				bvalid <= 1'b0;

			if (arvalid && !arready && !rd_pend && !rvalid) begin
				if (ar_cnt != 0) begin
					ar_cnt <= ar_cnt - 1'b1;
				end else begin
					arready <= 1'b1;
					rd_pend <= 1'b1;
					rd_addr <= araddr;
					r_cnt   <= pick_stall();
				end
			end
			if (rd_pend && !arready && mapped(rd_addr)) begin
				if (r_cnt != 0) begin
					r_cnt <= r_cnt - 1'b1;
				end else begin
					rvalid  <= 1'b1;
					rdata   <= mem[rd_addr[15:3]];
					rd_pend <= 1'b0;
					ar_cnt  <= pick_stall();
				end
			end

			if (awvalid && !awready && !aw_got) begin
				if (aw_cnt != 0) begin
					aw_cnt <= aw_cnt - 1'b1;
				end else begin
					awready <= 1'b1;
					aw_got  <= 1'b1;
					wr_addr <= awaddr;
				end
			end
			if (wvalid && !wready && !w_got) begin
				if (w_cnt != 0) begin
					w_cnt <= w_cnt - 1'b1;
				end else begin
					wready  <= 1'b1;
					w_got   <= 1'b1;
					wr_data <= wdata;
					wr_strb <= wstrb;
				end
			end
			if (aw_got && w_got && !awready && !wready && !bvalid && mapped(wr_addr)) begin
				if (b_cnt != 0) begin
					b_cnt <= b_cnt - 1'b1;
				end else begin
					mem[wr_addr[15:3]] <= merge_bytes(mem[wr_addr[15:3]], wr_data, wr_strb);
					bvalid <= 1'b1;
					aw_got <= 1'b0;
					w_got  <= 1'b0;
					aw_cnt <= pick_stall();
					w_cnt  <= pick_stall();
					b_cnt  <= pick_stall();
				end
			end
		end
	end

endmodule

// File: test/core_tb.sv
`timescale 1ns/1ps

module core_tb;

	localparam int MAX_CYCLES = 20000; // Six tests of about 3000 cycles each
	localparam int OPI = 7'b0010011, OPR = 7'b0110011, LUI = 7'b0110111;
	localparam int AUIPC = 7'b0010111, LD = 7'b0000011, JALR = 7'b1100111;
	localparam logic [31:0] ECALL = 32'h0000_0073;
	localparam logic [31:0] DATA = 32'h1000;

	logic        clk, rst, stall_en;
	logic [31:0] awaddr, araddr;
	logic        awvalid, awready, wvalid, wready, bvalid, bready;
	logic        arvalid, arready, rvalid, rready;
	logic [63:0] wdata, rdata;
	logic [7:0]  wstrb;
	logic [1:0]  bresp, rresp;
	logic        halted, illegal_inst, bus_error;
	logic [31:0] prog [$];
	int          cycles;

	core_top u_core_top (
		.clk(clk), .rst(rst),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
		.halted(halted), .illegal_inst(illegal_inst), .bus_error(bus_error)
	);

	axi_lite_mem u_mem (
		.clk(clk), .rst(rst), .stall_en(stall_en),
		.awaddr(awaddr), .awvalid(awvalid), .awready(awready),
		.wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
		.bresp(bresp), .bvalid(bvalid), .bready(bready),
		.araddr(araddr), .arvalid(arvalid), .arready(arready),
		.rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk;

	initial cycles = 0;
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Simulation ran past %0d cycles without finishing", MAX_CYCLES);
			$display("Test failed");
			$fatal(1, "Cycle limit reached");
		end
	end

	// Instruction encoders
	function automatic logic [31:0] r_type(input int f7, rs2, rs1, f3, rd);
		return {7'(f7), 5'(rs2), 5'(rs1), 3'(f3), 5'(rd), 7'(OPR)};
	endfunction

	function automatic logic [31:0] i_type(input int imm, rs1, f3, rd, op);
		return {12'(imm), 5'(rs1), 3'(f3), 5'(rd), 7'(op)};
	endfunction

	function automatic logic [31:0] s_type(input int imm, rs2, rs1);
		logic [11:0] v;
		v = 12'(imm);
		return {v[11:5], 5'(rs2), 5'(rs1), 3'b011, v[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_type(input int imm, rs2, rs1, f3);
		logic [12:0] v;
		v = 13'(imm);
		return {v[12], v[10:5], 5'(rs2), 5'(rs1), 3'(f3), v[4:1], v[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] u_type(input int imm, rd, op);
		return {20'(imm), 5'(rd), 7'(op)};
	endfunction

	function automatic logic [31:0] j_type(input int imm, rd);
		logic [20:0] v;
		v = 21'(imm);
		return {v[20], v[10:1], v[11], v[19:12], 5'(rd), 7'b1101111};
	endfunction

	// Untouched memory word at a byte address
	function automatic logic [63:0] blank(input logic [31:0] a);
		return {~a, a};
	endfunction

	task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1, "Value mismatch");
		end
	endtask

	// Reset, load the program while reset is held, then run until halted
	task automatic run_program(input logic stall);
		logic [31:0] hi;
		@(negedge clk);
		rst = 1'b1;
		stall_en = stall;
		u_mem.fill_all();
		for (int i = 0; i < prog.size(); i += 2) begin
			hi = (i + 1 < prog.size()) ? prog[i + 1] : 32'h0;
			u_mem.load_word(32'(i * 4), {hi, prog[i]});
		end
		repeat (5) @(negedge clk);
		rst = 1'b0;
		while (!halted)
			@(negedge clk);
	endtask

	task automatic arith_test(input string name, input logic stall);
		logic [63:0] a, b;
		a = -64'sd7;
		b = 64'd100;
		prog.delete();
		prog.push_back(u_type(1, 10, LUI));          // x10 = data base
		prog.push_back(i_type(-7, 0, 0, 1, OPI));
		prog.push_back(i_type(100, 0, 0, 2, OPI));
		prog.push_back(r_type(0, 2, 1, 0, 3));       // add
		prog.push_back(r_type(32, 2, 1, 0, 4));      // sub
		prog.push_back(r_type(0, 2, 1, 7, 5));       // and
		prog.push_back(r_type(0, 2, 1, 6, 6));       // or
		prog.push_back(r_type(0, 2, 1, 4, 7));       // xor
		prog.push_back(r_type(0, 2, 1, 2, 8));       // slt -7 < 100
		prog.push_back(r_type(0, 1, 2, 2, 9));       // slt 100 < -7
		prog.push_back(i_type(5, 0, 0, 0, OPI));     // Write to x0
		for (int r = 3; r <= 9; r++)
			prog.push_back(s_type((r - 3) * 8, r, 10));
		prog.push_back(s_type(56, 0, 10));
		prog.push_back(ECALL);
		run_program(stall);
		check({name, " add"}, a + b, u_mem.peek(DATA));
		check({name, " sub"}, a - b, u_mem.peek(DATA + 8));
		check({name, " and"}, a & b, u_mem.peek(DATA + 16));
		check({name, " or"}, a | b, u_mem.peek(DATA + 24));
		check({name, " xor"}, a ^ b, u_mem.peek(DATA + 32));
		check({name, " slt"}, ($signed(a) < $signed(b)) ? 64'd1 : 64'd0, u_mem.peek(DATA + 40));
		check({name, " slt rev"}, ($signed(b) < $signed(a)) ? 64'd1 : 64'd0, u_mem.peek(DATA + 48));
		check({name, " x0"}, 64'd0, u_mem.peek(DATA + 56));
	endtask

	// Preloaded data must be in place before the core leaves reset
	task automatic memory_test_preloaded();
		logic [63:0] w0, w1;
		logic [31:0] hi;
		w0 = 64'h1122_3344_5566_7788;
		w1 = 64'h8000_0000_0000_0001;
		prog.delete();
		prog.push_back(u_type(1, 10, LUI));
		prog.push_back(i_type(0, 10, 3, 1, LD));
		prog.push_back(i_type(8, 10, 3, 2, LD));
		prog.push_back(r_type(0, 2, 1, 0, 3));
		prog.push_back(s_type(16, 3, 10));
		prog.push_back(u_type(32'h80000, 4, LUI));
		prog.push_back(s_type(24, 4, 10));
		prog.push_back(u_type(32'h12, 5, AUIPC));   // At pc 28
		prog.push_back(s_type(32, 5, 10));
		prog.push_back(s_type(40, 1, 10));
		prog.push_back(ECALL);
		@(negedge clk);
		rst = 1'b1;
		stall_en = 1'b0;
		u_mem.fill_all();
		for (int i = 0; i < prog.size(); i += 2) begin
			hi = (i + 1 < prog.size()) ? prog[i + 1] : 32'h0;
			u_mem.load_word(32'(i * 4), {hi, prog[i]});
		end
		u_mem.load_word(DATA, w0);
		u_mem.load_word(DATA + 8, w1);
		repeat (5) @(negedge clk);
		rst = 1'b0;
		while (!halted)
			@(negedge clk);
		check("memory ld sum", w0 + w1, u_mem.peek(DATA + 16));
		check("memory lui", 64'hFFFF_FFFF_8000_0000, u_mem.peek(DATA + 24));
		check("memory auipc", 64'd28 + 64'h12000, u_mem.peek(DATA + 32));
		check("memory ld copy", w0, u_mem.peek(DATA + 40));
	endtask

	task automatic control_test();
		prog.delete();
		prog.push_back(u_type(1, 10, LUI));          // 0
		prog.push_back(i_type(0, 0, 0, 1, OPI));     // 4  sum
		prog.push_back(i_type(1, 0, 0, 2, OPI));     // 8  i
		prog.push_back(i_type(11, 0, 0, 3, OPI));    // 12 limit
		prog.push_back(r_type(0, 2, 1, 0, 1));       // 16 loop
		prog.push_back(i_type(1, 2, 0, 2, OPI));     // 20
		prog.push_back(b_type(-8, 3, 2, 1));         // 24 bne
		prog.push_back(b_type(8, 0, 0, 0));          // 28 beq taken
		prog.push_back(s_type(8, 0, 10));            // 32 skipped
		prog.push_back(s_type(0, 1, 10));            // 36
		prog.push_back(j_type(12, 5));               // 40 jal to 52
		prog.push_back(s_type(16, 0, 10));           // 44 skipped
		prog.push_back(s_type(16, 0, 10));           // 48 skipped
		prog.push_back(s_type(24, 5, 10));           // 52
		prog.push_back(i_type(72, 0, 0, 6, OPI));    // 56
		prog.push_back(i_type(4, 6, 0, 7, JALR));    // 60 jalr to 76
		prog.push_back(s_type(32, 0, 10));           // 64 skipped
		prog.push_back(s_type(32, 0, 10));           // 68 skipped
		prog.push_back(s_type(32, 0, 10));           // 72 skipped
		prog.push_back(s_type(40, 7, 10));           // 76
		prog.push_back(ECALL);
		run_program(1'b0);
		check("control loop sum", 64'd55, u_mem.peek(DATA));
		check("control beq skip", blank(DATA + 8), u_mem.peek(DATA + 8));
		check("control jal skip", blank(DATA + 16), u_mem.peek(DATA + 16));
		check("control jal link", 64'd44, u_mem.peek(DATA + 24));
		check("control jalr skip", blank(DATA + 32), u_mem.peek(DATA + 32));
		check("control jalr link", 64'd64, u_mem.peek(DATA + 40));
	endtask

	task automatic halting_test();
		prog.delete();
		prog.push_back(u_type(1, 10, LUI));
		prog.push_back(i_type(3, 0, 0, 1, OPI));
		prog.push_back(s_type(0, 1, 10));
		prog.push_back(ECALL);
		prog.push_back(s_type(8, 1, 10));            // Past the ecall
		run_program(1'b0);
		check("ecall illegal flag", 64'd0, 64'(illegal_inst));
		check("ecall store", 64'd3, u_mem.peek(DATA));
		check("ecall stop", blank(DATA + 8), u_mem.peek(DATA + 8));
		prog.delete();
		prog.push_back(u_type(1, 10, LUI));
		prog.push_back(i_type(5, 0, 0, 1, OPI));
		prog.push_back(32'hFFFF_FFFF);               // Opcode 7f is not supported
		prog.push_back(s_type(0, 1, 10));
		run_program(1'b0);
		check("illegal flag", 64'd1, 64'(illegal_inst));
		check("illegal bus error", 64'd0, 64'(bus_error));
		check("illegal stop", blank(DATA), u_mem.peek(DATA));
	endtask

	task automatic timeout_test();
		prog.delete();
		prog.push_back(u_type(32'h80000, 11, LUI));  // Base in the unmapped hole
		prog.push_back(i_type(0, 11, 3, 1, LD));
		prog.push_back(u_type(1, 10, LUI));
		prog.push_back(i_type(9, 0, 0, 2, OPI));
		prog.push_back(s_type(0, 2, 10));
		prog.push_back(ECALL);
		run_program(1'b0);
		check("timeout bus error", 64'd1, 64'(bus_error));
		repeat (10) @(negedge clk);                  // Halt must hold until reset
		check("timeout halted held", 64'd1, 64'(halted));
		check("timeout store", blank(DATA), u_mem.peek(DATA));
	endtask

	initial begin
		void'($urandom(89836));
		rst = 1'b1;
		stall_en = 1'b0;
		arith_test("arith", 1'b0);
		memory_test_preloaded();
		control_test();
		arith_test("backpressure", 1'b1);
		halting_test();
		timeout_test();
		$display("Test passed");
		$finish;
	end

endmodule

// File: sources.f
logic/rv_pkg.sv
logic/alu.sv
logic/reg_file.sv
logic/inst_decoder.sv
logic/bus_timeout_timer.sv
logic/exec_sequencer.sv
logic/core_top.sv
test/axi_lite_mem.sv
test/core_tb.sv

// File: Makefile
# Verilator build and run for the RV64I core testbench

VERILATOR ?= verilator
TOP       ?= core_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -q '^Test passed$$' $(LOG) || { echo "Simulation did not pass"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
